// ==== ctrl_pkg.sv ====
//////////////////////////////
// shared types and constants for the core controller
// cause constants are CAUSE_W wide and assume machine-mode traps
// enum encodings match the fetch stage and CSR file muxes
//////////////////////////////

package ctrl_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // interrupt id from the interrupt controller
  localparam int unsigned IRQ_ID_W = 5;
  // msb of a cause flags an interrupt
  localparam int unsigned CAUSE_W  = IRQ_ID_W + 1;

  //////////////////////////////
  // state and selects
  //////////////////////////////

  // controller FSM states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_t;

  // pc source in the fetch stage, gaps are sources outside this controller
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd2,
    PC_EXCEPTION = 3'd4,
    PC_ERET      = 3'd5
  } pc_sel_t;

  // exception vector select
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'd0,
    EXC_PC_ECALL   = 2'd1,
    EXC_PC_IRQ     = 2'd3
  } exc_pc_sel_t;

  // why the pipeline is being flushed
  typedef enum logic [2:0] {
    FLUSH_NONE,
    FLUSH_ILLEGAL,
    FLUSH_ECALL,
    FLUSH_MRET,
    FLUSH_PIPE
  } flush_kind_t;

  // trap taken in the current cycle
  typedef enum logic [2:0] {
    TRAP_NONE,
    TRAP_IRQ,
    TRAP_ECALL,
    TRAP_ILLEGAL,
    TRAP_MRET
  } trap_sel_t;

  // privilege level, machine mode only in practice
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_H = 2'd2,
    PRIV_LVL_M = 2'd3
  } priv_lvl_t;

  //////////////////////////////
  // exception causes
  //////////////////////////////

  // low bits take the privilege level
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ECALL   = 6'h08;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ILLEGAL = 6'h02;

endpackage

// ==== insn_classifier.sv ====
//////////////////////////////
// reduces decoder flags to one flush request and interrupt terms
// flush kind is latched only while decoding a valid instruction
// kill hint is not masked by jump_set_i, a hint only
//////////////////////////////

`timescale 1ns/1ps

module insn_classifier (
  input  logic                 clk,
  input  logic                 rst_n,

  // decoder flags for the instruction in ID
  input  logic                 instr_valid_i,
  input  logic                 illegal_insn_i,
  input  logic                 ecall_insn_i,
  input  logic                 mret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 instr_multicycle_i,
  input  logic                 branch_in_id_i,

  // interrupt side
  input  logic                 irq_req_i,
  input  logic                 m_ie_i,

  // from the sequencer
  input  logic                 decode_active_i,

  output logic                 flush_req_o,
  output logic                 irq_take_ok_o,
  output logic                 irq_pending_o,
  output logic                 exc_kill_o,
  output logic                 deassert_we_o,
  output ctrl_pkg::flush_kind_t flush_kind_o
);

  import ctrl_pkg::*;

  // kind of the flush request in this cycle, before latching
  flush_kind_t flush_kind_d;
  flush_kind_t flush_kind_q;

  // any flushing instruction, valid only
  assign flush_req_o = instr_valid_i &
                       (illegal_insn_i | ecall_insn_i | mret_insn_i | pipe_flush_i);

  // ecall first, then illegal, then mret, then pipe flush
  always_comb begin
    flush_kind_d = FLUSH_NONE;
    if (ecall_insn_i) begin
      flush_kind_d = FLUSH_ECALL;
    end else if (illegal_insn_i) begin
      flush_kind_d = FLUSH_ILLEGAL;
    end else if (mret_insn_i) begin
      flush_kind_d = FLUSH_MRET;
    end else if (pipe_flush_i) begin
      flush_kind_d = FLUSH_PIPE;
    end
  end

  // capture on flush entry so FLUSH does not need the decoder to hold
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_kind_q <= FLUSH_NONE;
    end else if (decode_active_i && flush_req_o) begin
      flush_kind_q <= flush_kind_d;
    end
  end

  assign flush_kind_o = flush_kind_q;

  //////////////////////////////
  // interrupt terms
  //////////////////////////////

  // enabled interrupt, regardless of what sits in ID
  assign irq_pending_o = irq_req_i & m_ie_i;
  // safe to take now: no multicycle op and no branch in flight
  assign irq_take_ok_o = irq_pending_o & ~instr_multicycle_i & ~branch_in_id_i;

  // request seen while disabled and nothing else going on in decode
  assign exc_kill_o = decode_active_i & ~flush_req_o & ~irq_take_ok_o &
                      irq_req_i & ~instr_multicycle_i & ~branch_in_id_i;

  // no writeback unless decoding, never for an illegal instruction
  assign deassert_we_o = ~decode_active_i | illegal_insn_i;

endmodule

// ==== ctrl_fsm.sv ====
//////////////////////////////
// controller sequencer, all outputs combinational from state and inputs
// flush_kind_i must be the kind latched on FLUSH entry
//////////////////////////////

`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic                  id_ready_i,
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,

  // from the classifier
  input  logic                  flush_req_i,
  input  logic                  irq_take_ok_i,
  input  logic                  irq_pending_i,
  input  logic                  irq_req_i,
  input  ctrl_pkg::flush_kind_t flush_kind_i,

  output logic                  ctrl_busy_o,
  output logic                  first_fetch_o,
  output logic                  is_decoding_o,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o,
  output ctrl_pkg::pc_sel_t     pc_mux_o,
  output ctrl_pkg::trap_sel_t   trap_sel_o,
  output logic                  decode_active_o
);

  import ctrl_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  //////////////////////////////
  // state register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb begin
    // defaults: busy and fetching, no redirect, no halt
    state_d       = state_q;
    ctrl_busy_o   = 1'b1;
    instr_req_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = PC_BOOT;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    trap_sel_o    = TRAP_NONE;

    unique case (state_q)
      // idle until the core is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch stage
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // one cycle to let the pipeline drain before sleeping
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      // wake on enable or on any interrupt request, enabled or not
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || irq_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction, an interrupt overrides
      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_i) begin
          state_d = DECODE;
        end
        if (irq_pending_i) begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN;
        end
      end

      DECODE: begin
        if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          // branch, jump, flush, interrupt in that order
          if (branch_set_i || jump_set_i) begin
            pc_set_o = 1'b1;
            pc_mux_o = PC_JUMP;
          end else if (flush_req_i) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH;
          end else if (irq_take_ok_i) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = IRQ_TAKEN;
          end
        end else if (irq_pending_i) begin
          // empty ID stage, nothing to protect
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN;
        end
      end

      // jump to the interrupt vector, causes come from the mapper
      IRQ_TAKEN: begin
        pc_set_o   = 1'b1;
        pc_mux_o   = PC_EXCEPTION;
        trap_sel_o = TRAP_IRQ;
        state_d    = DECODE;
      end

      // ID holds a NOP, action depends on the latched kind
      FLUSH: begin
        halt_id_o = 1'b1;
        halt_if_o = ~fetch_enable_i;
        unique case (flush_kind_i)
          FLUSH_ECALL: begin
            pc_set_o   = 1'b1;
            pc_mux_o   = PC_EXCEPTION;
            trap_sel_o = TRAP_ECALL;
          end
          FLUSH_ILLEGAL: begin
            pc_set_o   = 1'b1;
            pc_mux_o   = PC_EXCEPTION;
            trap_sel_o = TRAP_ILLEGAL;
          end
          FLUSH_MRET: begin
            pc_set_o   = 1'b1;
            pc_mux_o   = PC_ERET;
            trap_sel_o = TRAP_MRET;
          end
          // pipe flush only drains, no redirect
          default: begin
            trap_sel_o = TRAP_NONE;
          end
        endcase

        // mret or wfi-like flush with fetch disabled puts the core to sleep
        if (!fetch_enable_i &&
            (flush_kind_i == FLUSH_MRET || flush_kind_i == FLUSH_PIPE)) begin
          state_d = WAIT_SLEEP;
        end else begin
          state_d = DECODE;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // the classifier latches flush kind and gates its hints on this
  assign decode_active_o = is_decoding_o;

endmodule

// ==== trap_cause_gen.sv ====
//////////////////////////////
// maps the trap of this cycle to vector, causes and CSR strobes
// irq_id_w must be at least 5 so the exception causes fit
//////////////////////////////

`timescale 1ns/1ps

module trap_cause_gen #(
  parameter int unsigned irq_id_w = ctrl_pkg::IRQ_ID_W
) (
  input  ctrl_pkg::trap_sel_t   trap_sel_i,
  input  logic [irq_id_w-1:0]   irq_id_i,
  input  ctrl_pkg::priv_lvl_t   m_prv_i,

  output ctrl_pkg::exc_pc_sel_t exc_pc_mux_o,
  output logic [irq_id_w:0]     exc_cause_o,
  output logic [irq_id_w:0]     csr_cause_o,
  output logic [irq_id_w-1:0]   irq_id_o,
  output logic                  irq_ack_o,
  output logic                  exc_ack_o,
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output logic                  csr_save_cause_o,
  output logic                  csr_restore_mret_o
);

  import ctrl_pkg::*;

  // one extra bit on top of the id marks an interrupt
  localparam int unsigned cause_w = irq_id_w + 1;

  // ecall cause depends on the mode the call came from
  logic [CAUSE_W-1:0] ecall_cause;

  assign ecall_cause = EXC_CAUSE_ECALL | {{(CAUSE_W-2){1'b0}}, m_prv_i};

  // id goes straight through, only meaningful with irq_ack_o
  assign irq_id_o = irq_id_i;

  always_comb begin
    // no trap: quiet strobes, zero causes
    exc_pc_mux_o       = EXC_PC_IRQ;
    exc_cause_o        = '0;
    csr_cause_o        = '0;
    irq_ack_o          = 1'b0;
    exc_ack_o          = 1'b0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;

    unique case (trap_sel_i)
      // save the IF pc, the interrupted instruction never issued
      TRAP_IRQ: begin
        exc_pc_mux_o     = EXC_PC_IRQ;
        exc_cause_o      = {1'b0, irq_id_i};
        csr_cause_o      = {1'b1, irq_id_i};
        irq_ack_o        = 1'b1;
        exc_ack_o        = 1'b1;
        csr_save_if_o    = 1'b1;
        csr_save_cause_o = 1'b1;
      end
      // synchronous traps save the pc of the instruction in ID
      TRAP_ECALL: begin
        exc_pc_mux_o     = EXC_PC_ECALL;
        exc_cause_o      = cause_w'(ecall_cause);
        csr_cause_o      = cause_w'(ecall_cause);
        csr_save_id_o    = 1'b1;
        csr_save_cause_o = 1'b1;
      end
      TRAP_ILLEGAL: begin
        exc_pc_mux_o     = EXC_PC_ILLINSN;
        exc_cause_o      = cause_w'(EXC_CAUSE_ILLEGAL);
        csr_cause_o      = cause_w'(EXC_CAUSE_ILLEGAL);
        csr_save_id_o    = 1'b1;
        csr_save_cause_o = 1'b1;
      end
      // return restores mstatus, the pc comes from mepc
      TRAP_MRET: begin
        csr_restore_mret_o = 1'b1;
      end
      default: begin
        exc_pc_mux_o = EXC_PC_IRQ;
      end
    endcase
  end

endmodule

// ==== ctrl_top.sv ====
//////////////////////////////
// main controller of the in-order core, no debug unit
// irq_id_w sets the interrupt id width, causes are one bit wider
//////////////////////////////

`timescale 1ns/1ps

module ctrl_top #(
  parameter int unsigned irq_id_w = ctrl_pkg::IRQ_ID_W
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // core enable and status
  input  logic                  fetch_enable_i,
  output logic                  ctrl_busy_o,
  output logic                  first_fetch_o,
  output logic                  is_decoding_o,

  // decoder
  output logic                  deassert_we_o,
  input  logic                  illegal_insn_i,
  input  logic                  ecall_insn_i,
  input  logic                  mret_insn_i,
  input  logic                  pipe_flush_i,
  input  logic                  instr_valid_i,

  // fetch stage
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_sel_t     pc_mux_o,
  output ctrl_pkg::exc_pc_sel_t exc_pc_mux_o,

  // branches, jumps and multicycle ops
  input  logic                  branch_in_id_i,
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  input  logic                  instr_multicycle_i,

  // interrupt controller and CSR file
  input  logic                  irq_req_i,
  input  logic [irq_id_w-1:0]   irq_id_i,
  input  logic                  m_ie_i,
  input  ctrl_pkg::priv_lvl_t   m_prv_i,
  output logic                  irq_ack_o,
  output logic [irq_id_w-1:0]   irq_id_o,
  output logic [irq_id_w:0]     exc_cause_o,
  output logic                  exc_ack_o,
  output logic                  exc_kill_o,
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output logic [irq_id_w:0]     csr_cause_o,
  output logic                  csr_restore_mret_o,
  output logic                  csr_save_cause_o,

  // stalls
  output logic                  halt_if_o,
  output logic                  halt_id_o,
  input  logic                  id_ready_i
);

  import ctrl_pkg::*;

  // classifier to sequencer
  logic        flush_req;
  logic        irq_take_ok;
  logic        irq_pending;
  flush_kind_t flush_kind;

  // sequencer back to classifier and on to the cause mapper
  logic        decode_active;
  trap_sel_t   trap_sel;

  //////////////////////////////
  // classify
  //////////////////////////////

  insn_classifier u_insn_classifier (
    .clk                (clk),
    .rst_n              (rst_n),
    .instr_valid_i      (instr_valid_i),
    .illegal_insn_i     (illegal_insn_i),
    .ecall_insn_i       (ecall_insn_i),
    .mret_insn_i        (mret_insn_i),
    .pipe_flush_i       (pipe_flush_i),
    .instr_multicycle_i (instr_multicycle_i),
    .branch_in_id_i     (branch_in_id_i),
    .irq_req_i          (irq_req_i),
    .m_ie_i             (m_ie_i),
    .decode_active_i    (decode_active),
    .flush_req_o        (flush_req),
    .irq_take_ok_o      (irq_take_ok),
    .irq_pending_o      (irq_pending),
    .exc_kill_o         (exc_kill_o),
    .deassert_we_o      (deassert_we_o),
    .flush_kind_o       (flush_kind)
  );

  //////////////////////////////
  // sequence
  //////////////////////////////

  ctrl_fsm u_ctrl_fsm (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_enable_i  (fetch_enable_i),
    .instr_valid_i   (instr_valid_i),
    .id_ready_i      (id_ready_i),
    .branch_set_i    (branch_set_i),
    .jump_set_i      (jump_set_i),
    .flush_req_i     (flush_req),
    .irq_take_ok_i   (irq_take_ok),
    .irq_pending_i   (irq_pending),
    .irq_req_i       (irq_req_i),
    .flush_kind_i    (flush_kind),
    .ctrl_busy_o     (ctrl_busy_o),
    .first_fetch_o   (first_fetch_o),
    .is_decoding_o   (is_decoding_o),
    .instr_req_o     (instr_req_o),
    .pc_set_o        (pc_set_o),
    .halt_if_o       (halt_if_o),
    .halt_id_o       (halt_id_o),
    .pc_mux_o        (pc_mux_o),
    .trap_sel_o      (trap_sel),
    .decode_active_o (decode_active)
  );

  //////////////////////////////
  // map causes
  //////////////////////////////

  trap_cause_gen #(
    .irq_id_w (irq_id_w)
  ) u_trap_cause_gen (
    .trap_sel_i         (trap_sel),
    .irq_id_i           (irq_id_i),
    .m_prv_i            (m_prv_i),
    .exc_pc_mux_o       (exc_pc_mux_o),
    .exc_cause_o        (exc_cause_o),
    .csr_cause_o        (csr_cause_o),
    .irq_id_o           (irq_id_o),
    .irq_ack_o          (irq_ack_o),
    .exc_ack_o          (exc_ack_o),
    .csr_save_if_o      (csr_save_if_o),
    .csr_save_id_o      (csr_save_id_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_restore_mret_o (csr_restore_mret_o)
  );

endmodule

// ==== tb_ctrl_vectors.svh ====
//////////////////////////////
// controller vectors, one row per cycle after reset release
// rows depend on the ones before, the FSM state carries over
//////////////////////////////

`ifndef TB_CTRL_VECTORS_SVH
`define TB_CTRL_VECTORS_SVH

// add_row(in, prv, id, out, pc_mux, exc_pc_mux, exc_cause, csr_cause)
// in  : fe iv _ ill ecall mret pflush _ bin_id bset jset mcycle _ irq m_ie id_ready
// out : busy ffetch dec dwe ireq _ pcset iack eack kill _ sif sid smret scause _ hif hid
// id -1 takes a random id, pc_mux and exc_pc_mux -1 skip the check
task automatic load_vectors();
  // reset idle, then boot
  add_row(13'b00_0000_0000_000, 3,  -1, 15'b00010_0000_0000_00, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_000, 3,  -1, 15'b00010_0000_0000_00, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_000, 3,  -1, 15'b10011_1000_0000_00,  0, 3, 6'h00, 6'h00);
  // first fetch held until id_ready
  add_row(13'b10_0000_0000_000, 3,  -1, 15'b11011_0000_0000_00, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_001, 3,  -1, 15'b11011_0000_0000_00, -1, 3, 6'h00, 6'h00);
  add_row(13'b11_0000_0000_000, 3,  -1, 15'b10101_0000_0000_00, -1, 3, 6'h00, 6'h00);
  // branch, jump, branch beats ecall
  add_row(13'b11_0000_0100_000, 3,  -1, 15'b10101_1000_0000_00,  2, 3, 6'h00, 6'h00);
  add_row(13'b11_0000_0010_000, 3,  -1, 15'b10101_1000_0000_00,  2, 3, 6'h00, 6'h00);
  add_row(13'b11_0100_0100_000, 3,  -1, 15'b10101_1000_0000_00,  2, 3, 6'h00, 6'h00);
  // illegal flush, write enable dropped
  add_row(13'b11_1000_0000_000, 3,  -1, 15'b10111_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_000, 3,  -1, 15'b10011_1000_0101_01,  4, 0, 6'h02, 6'h02);
  // ecall from user mode
  add_row(13'b11_0100_0000_000, 0,  -1, 15'b10101_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_000, 0,  -1, 15'b10011_1000_0101_01,  4, 1, 6'h08, 6'h08);
  // ecall from machine mode
  add_row(13'b11_0100_0000_000, 3,  -1, 15'b10101_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_000, 3,  -1, 15'b10011_1000_0101_01,  4, 1, 6'h0b, 6'h0b);
  // enabled interrupt while decoding
  add_row(13'b11_0000_0000_110, 3, 'h0b, 15'b10101_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_110, 3, 'h0b, 15'b10011_1110_1001_00,  4, 3, 6'h0b, 6'h2b);
  // disabled interrupt only raises the kill hint
  add_row(13'b11_0000_0000_100, 3,  -1, 15'b10101_0001_0000_00, -1, 3, 6'h00, 6'h00);
  // branch in ID defers the interrupt, taken a cycle later
  add_row(13'b11_0000_1000_110, 3,  -1, 15'b10101_0000_0000_00, -1, 3, 6'h00, 6'h00);
  add_row(13'b11_0000_0000_110, 3, 'h03, 15'b10101_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_110, 3, 'h03, 15'b10011_1110_1001_00,  4, 3, 6'h03, 6'h23);
  // mret with fetch off, then sleep
  add_row(13'b01_0010_0000_000, 3,  -1, 15'b10101_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b00_0000_0000_000, 3,  -1, 15'b10011_1000_0010_11,  5, -1, 6'h00, 6'h00);
  add_row(13'b00_0000_0000_000, 3,  -1, 15'b00010_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b00_0000_0000_000, 3,  -1, 15'b00010_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b00_0000_0000_000, 3,  -1, 15'b00010_0000_0000_11, -1, 3, 6'h00, 6'h00);
  // an interrupt request wakes the core, enabled or not
  add_row(13'b00_0000_0000_100, 3,  -1, 15'b00010_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_000, 3,  -1, 15'b11011_0000_0000_00, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_001, 3,  -1, 15'b11011_0000_0000_00, -1, 3, 6'h00, 6'h00);
  // pipe flush with fetch on, back to decode without redirect
  add_row(13'b11_0001_0000_000, 3,  -1, 15'b10101_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_000, 3,  -1, 15'b10011_0000_0000_01, -1, 3, 6'h00, 6'h00);
  add_row(13'b11_0000_0000_000, 3,  -1, 15'b10101_0000_0000_00, -1, 3, 6'h00, 6'h00);
  // empty ID stage takes the interrupt even with a multicycle flag
  add_row(13'b10_0000_0001_110, 3, 'h1f, 15'b10011_0000_0000_11, -1, 3, 6'h00, 6'h00);
  add_row(13'b10_0000_0000_110, 3, 'h1f, 15'b10011_1110_1001_00,  4, 3, 6'h1f, 6'h3f);
  add_row(13'b11_0000_0000_000, 3,  -1, 15'b10101_0000_0000_00, -1, 3, 6'h00, 6'h00);
endtask

`endif

// ==== tb_ctrl_top.sv ====
//////////////////////////////
// testbench for the core controller with one table row per clock cycle
// inputs change 1 ns after the rising edge and outputs are sampled 1 ns before the next one
// stops at the first mismatch
//////////////////////////////

`timescale 1ns/1ps

module tb_ctrl_top;

  import ctrl_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DLY    = 1;
  // sample one ns before the next rising edge
  localparam int SAMPLE_DLY   = CLK_PERIOD - DRIVE_DLY - 1;
  localparam int SLACK_CYCLES = 20;
  localparam int unsigned RNG_SEED = 32'h20b4;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic clk;
  logic rst_n;

  logic fetch_enable, instr_valid, id_ready;
  logic illegal_insn, ecall_insn, mret_insn, pipe_flush;
  logic branch_in_id, branch_set, jump_set, instr_multicycle;
  logic irq_req, m_ie;
  logic [IRQ_ID_W-1:0] irq_id;
  priv_lvl_t m_prv;

  logic ctrl_busy, first_fetch, is_decoding, deassert_we;
  logic instr_req, pc_set, halt_if, halt_id;
  pc_sel_t pc_mux;
  exc_pc_sel_t exc_pc_mux;
  logic irq_ack, exc_ack, exc_kill;
  logic csr_save_if, csr_save_id, csr_restore_mret, csr_save_cause;
  logic [IRQ_ID_W-1:0] irq_id_out;
  logic [IRQ_ID_W:0] exc_cause, csr_cause;

  //////////////////////////////
  // vector table filled by load_vectors
  //////////////////////////////

  logic [12:0]         in_q [$];
  logic [1:0]          prv_q [$];
  logic [IRQ_ID_W-1:0] id_q [$];
  logic [14:0]         out_q [$];
  int                  pcm_q [$];
  int                  epc_q [$];
  logic [CAUSE_W-1:0]  exc_cause_q [$];
  logic [CAUSE_W-1:0]  csr_cause_q [$];

  // names of the output flag column with the msb first
  string flag_name [0:14] = '{
    "ctrl_busy_o", "first_fetch_o", "is_decoding_o", "deassert_we_o", "instr_req_o",
    "pc_set_o", "irq_ack_o", "exc_ack_o", "exc_kill_o",
    "csr_save_if_o", "csr_save_id_o", "csr_restore_mret_o", "csr_save_cause_o",
    "halt_if_o", "halt_id_o"
  };

  int cycle_cnt   = 0;
  int cycle_limit = RESET_CYCLES + SLACK_CYCLES;

  ctrl_top #(
    .irq_id_w (IRQ_ID_W)
  ) dut_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable),
    .ctrl_busy_o        (ctrl_busy),
    .first_fetch_o      (first_fetch),
    .is_decoding_o      (is_decoding),
    .deassert_we_o      (deassert_we),
    .illegal_insn_i     (illegal_insn),
    .ecall_insn_i       (ecall_insn),
    .mret_insn_i        (mret_insn),
    .pipe_flush_i       (pipe_flush),
    .instr_valid_i      (instr_valid),
    .instr_req_o        (instr_req),
    .pc_set_o           (pc_set),
    .pc_mux_o           (pc_mux),
    .exc_pc_mux_o       (exc_pc_mux),
    .branch_in_id_i     (branch_in_id),
    .branch_set_i       (branch_set),
    .jump_set_i         (jump_set),
    .instr_multicycle_i (instr_multicycle),
    .irq_req_i          (irq_req),
    .irq_id_i           (irq_id),
    .m_ie_i             (m_ie),
    .m_prv_i            (m_prv),
    .irq_ack_o          (irq_ack),
    .irq_id_o           (irq_id_out),
    .exc_cause_o        (exc_cause),
    .exc_ack_o          (exc_ack),
    .exc_kill_o         (exc_kill),
    .csr_save_if_o      (csr_save_if),
    .csr_save_id_o      (csr_save_id),
    .csr_cause_o        (csr_cause),
    .csr_restore_mret_o (csr_restore_mret),
    .csr_save_cause_o   (csr_save_cause),
    .halt_if_o          (halt_if),
    .halt_id_o          (halt_id),
    .id_ready_i         (id_ready)
  );

  `include "tb_ctrl_vectors.svh"

  //////////////////////////////
  // helpers
  //////////////////////////////

  // negative id means any id will do
  task automatic add_row(input logic [12:0] in_flags, input int prv, input int id,
                         input logic [14:0] out_flags, input int pcm, input int epc,
                         input logic [CAUSE_W-1:0] exc_c, input logic [CAUSE_W-1:0] csr_c);
    logic [IRQ_ID_W-1:0] id_v;
    if (id < 0) begin
      id_v = IRQ_ID_W'($urandom);
    end else begin
      id_v = IRQ_ID_W'(id);
    end
    in_q.push_back(in_flags);
    prv_q.push_back(2'(prv));
    id_q.push_back(id_v);
    out_q.push_back(out_flags);
    pcm_q.push_back(pcm);
    epc_q.push_back(epc);
    exc_cause_q.push_back(exc_c);
    csr_cause_q.push_back(csr_c);
  endtask

  task automatic drive_inputs(input int i);
    {fetch_enable, instr_valid, illegal_insn, ecall_insn, mret_insn, pipe_flush,
     branch_in_id, branch_set, jump_set, instr_multicycle,
     irq_req, m_ie, id_ready} = in_q[i];
    m_prv  = priv_lvl_t'(prv_q[i]);
    irq_id = id_q[i];
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0d ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "output mismatch on %s", name);
    end
  endtask

  task automatic compare_outputs(input int i);
    logic [14:0] act;
    act = {ctrl_busy, first_fetch, is_decoding, deassert_we, instr_req,
           pc_set, irq_ack, exc_ack, exc_kill,
           csr_save_if, csr_save_id, csr_restore_mret, csr_save_cause,
           halt_if, halt_id};
    for (int b = 14; b >= 0; b--) begin
      check_value(flag_name[14-b], 32'(act[b]), 32'(out_q[i][b]));
    end
    // pc_mux only matters while pc_set is high
    if (pcm_q[i] >= 0) begin
      check_value("pc_mux_o", 32'(pc_mux), pcm_q[i]);
    end
    if (epc_q[i] >= 0) begin
      check_value("exc_pc_mux_o", 32'(exc_pc_mux), epc_q[i]);
    end
    check_value("exc_cause_o", 32'(exc_cause), 32'(exc_cause_q[i]));
    check_value("csr_cause_o", 32'(csr_cause), 32'(csr_cause_q[i]));
    // id is only meaningful with the ack
    if (out_q[i][8]) begin
      check_value("irq_id_o", 32'(irq_id_out), 32'(id_q[i]));
    end
  endtask

  //////////////////////////////
  // clock and timeout
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: vector loop still running after %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    void'($urandom(RNG_SEED));
    rst_n            = 1'b0;
    fetch_enable     = 1'b0;
    instr_valid      = 1'b0;
    id_ready         = 1'b0;
    illegal_insn     = 1'b0;
    ecall_insn       = 1'b0;
    mret_insn        = 1'b0;
    pipe_flush       = 1'b0;
    branch_in_id     = 1'b0;
    branch_set       = 1'b0;
    jump_set         = 1'b0;
    instr_multicycle = 1'b0;
    irq_req          = 1'b0;
    m_ie             = 1'b0;
    irq_id           = '0;
    m_prv            = PRIV_LVL_M;

    load_vectors();
    cycle_limit = RESET_CYCLES + in_q.size() + SLACK_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;
    for (int i = 0; i < in_q.size(); i++) begin
      if (i > 0) begin
        @(posedge clk);
        #(DRIVE_DLY);
      end
      drive_inputs(i);
      #(SAMPLE_DLY);
      compare_outputs(i);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
ctrl_pkg.sv
insn_classifier.sv
ctrl_fsm.sv
trap_cause_gen.sv
ctrl_top.sv
tb_ctrl_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -j 0 --top-module tb_ctrl_top -f all.f \
  -Mdir obj_dir -o tb_ctrl_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_ctrl_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi
exit 0
